/* bench/exec_unit_checker.sv */
/*
 * Protocol and EFLAGS assertions for the execute unit.
 * Bound into every exec_unit instance; failures report through $error.
 */
module exec_unit_checker (
	input logic                clk,
	input logic                rst_n,
	input logic                busy,
	input logic                done,
	input exec_pkg::exec_rsp_t rsp
);

	// Failed assertions so far
	int unsigned fail_count = 0;

	// Done is a single-cycle pulse
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else begin
			fail_count++;
			$error("done stayed high for more than one cycle");
		end

	// Busy drops in the same cycle done rises
	busy_drop: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> !busy && $past(busy))
		else begin
			fail_count++;
			$error("busy did not fall as done rose");
		end

	// Reserved EFLAGS fields never set
	rsvd_zero: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.flags.rsvd_31_12 == '0 && rsp.flags.rsvd_9_8 == '0 &&
		!rsp.flags.rsvd_5 && !rsp.flags.rsvd_3 && !rsp.flags.rsvd_1)
		else begin
			fail_count++;
			$error("reserved EFLAGS bit set: %h", rsp.flags);
		end

endmodule

bind exec_unit exec_unit_checker u_checker (
	.clk   (clk),
	.rst_n (rst_n),
	.busy  (busy),
	.done  (done),
	.rsp   (rsp)
);

/* bench/exec_unit_tb.sv */
/*
 * Testbench for the integer execute unit.
 * Reads requests and expected results from bench/exec_unit_tests.txt,
 * runs them one at a time and compares result, EFLAGS and done latency.
 * Run from the project root with exec_unit.f.
 */
module exec_unit_tb;
	import exec_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      start;
	exec_req_t req;
	logic      busy;
	logic      done;
	exec_rsp_t rsp;

	// Tests as read from the data file
	exec_req_t   req_q[$];
	logic [31:0] res_q[$];
	eflags_t     flags_q[$];
	int          errors;
	int          failed_tests;
	int          cycle_count;
	int          cycle_limit;
	bit          limit_set;

	exec_unit u_exec_unit (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.req   (req),
		.busy  (busy),
		.done  (done),
		.rsp   (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog, limit known once the data file is read
	initial begin
		cycle_count = 0;
		wait (limit_set);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: tests did not finish within %0d cycles", cycle_limit);
		$display("TB FAILED");
		$finish;
	end

	//----------------------------------------------------------------------
	// Decoding of the data file and expected timing
	//----------------------------------------------------------------------
	function automatic int op_code_of(string name);
		case (name)
			"add":   return int'(op_add);
			"sub":   return int'(op_sub);
			"and":   return int'(op_and);
			"or":    return int'(op_or);
			"xor":   return int'(op_xor);
			"shl":   return int'(op_shl);
			"cld":   return int'(op_cld);
			"std":   return int'(op_std);
			default: return -1;
		endcase
	endfunction

	function automatic op_size_e size_of_bits(int bits);
		case (bits)
			8:       return size_8;
			16:      return size_16;
			default: return size_32;
		endcase
	endfunction

	// Shift loop takes one cycle per bit after the execute cycle
	function automatic int expected_latency(exec_op_e op, logic [4:0] count);
		if (op == op_shl)
			return int'(count) + 1;
		return 1;
	endfunction

	task automatic load_tests();
		int          fd;
		int          code;
		int          fields;
		int          bits;
		int          cnt;
		string       line;
		string       name;
		exec_req_t   r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp_res;
		logic [31:0] exp_flags;
		cycle_limit = 50;
		fd = $fopen("bench/exec_unit_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/exec_unit_tests.txt");
			errors = errors + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank lines and column notes
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %d %h %h %d %h %h", name, bits, a, b, cnt,
						exp_res, exp_flags);
					code = op_code_of(name);
					if (fields != 7 || code < 0 || !(bits inside {8, 16, 32}) ||
							cnt < 0 || cnt > 31) begin
						$display("Malformed test line: %s", line);
						errors = errors + 1;
					end else begin
						r.op    = exec_op_e'(code[2:0]);
						r.size  = size_of_bits(bits);
						r.a     = a;
						r.b     = b;
						r.count = cnt[4:0];
						req_q.push_back(r);
						res_q.push_back(exp_res);
						flags_q.push_back(eflags_t'(exp_flags));
						cycle_limit = cycle_limit + cnt + 4;
					end
				end
			end
			$fclose(fd);
		end
		if (req_q.size() == 0) begin
			$display("No tests found in the data file");
			errors = errors + 1;
		end
		limit_set = 1'b1;
	endtask

	//----------------------------------------------------------------------
	// Compare tasks
	//----------------------------------------------------------------------
	task automatic check_result(logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t rsp.result got %h expected %h", $time, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_eflags(eflags_t got, eflags_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t rsp.flags got %h expected %h", $time, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_latency(int got, int exp);
		if (got != exp) begin
			$display("FAIL t=%0t done latency got %0d expected %0d", $time, got, exp);
			errors = errors + 1;
		end
	endtask

	// One request, start pulse to done, then compare
	task automatic run_test(int idx);
		exec_req_t r;
		int        lat;
		int        errs_before;
		r = req_q[idx];
		errs_before = errors;
		@(negedge clk);
		req   = r;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		lat = 0;
		while (!done) begin
			@(negedge clk);
			lat = lat + 1;
			// Second request mid shift, must be ignored
			if (lat == 1 && r.op == op_shl && r.count > 5'd1) begin
				if (busy !== 1'b1) begin
					$display("DUT not busy during the shift loop of test %0d", idx + 1);
					errors = errors + 1;
				end
				req   = '{op: op_add, size: size_32, a: ~r.a, b: 32'h1, count: 5'd7};
				start = 1'b1;
			end else if (lat == 2) begin
				start = 1'b0;
			end
		end
		check_result(rsp.result, res_q[idx]);
		check_eflags(rsp.flags, flags_q[idx]);
		check_latency(lat, expected_latency(r.op, r.count));
		if (errors == errs_before) begin
			$display("test %0d %s %s count %0d: ok", idx + 1, r.op.name(), r.size.name(),
				r.count);
		end else begin
			failed_tests = failed_tests + 1;
			$display("test %0d %s %s count %0d: mismatch", idx + 1, r.op.name(),
				r.size.name(), r.count);
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		start        = 1'b0;
		req          = '0;
		errors       = 0;
		failed_tests = 0;
		limit_set    = 1'b0;
		load_tests();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (busy !== 1'b0 || done !== 1'b0 || rsp !== '0) begin
			$display("DUT outputs not idle and zero after reset");
			errors = errors + 1;
		end
		for (int i = 0; i < req_q.size(); i++)
			run_test(i);
		// Protocol assertions in the bound checker count as errors
		errors = errors + int'(u_exec_unit.u_checker.fail_count);
		$display("%0d tests, %0d passed, %0d failed, %0d errors", req_q.size(),
			req_q.size() - failed_tests, failed_tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* bench/exec_unit_tests.txt */
# op size(8/16/32) a(hex) b(hex) count(dec) result(hex) eflags(hex)
# tests run in order, flags carry over from one test to the next
add 8 0000007f 00000001 0 00000080 00000890
add 16 1234ffff 00000001 0 00000000 00000055
add 32 7fffffff 00000001 0 80000000 00000894
sub 8 00000080 00000001 0 0000007f 00000810
sub 8 00000000 00000001 0 000000ff 00000095
xor 16 0000ffff 00000f0e 0 0000f0f1 00000080
sub 16 00001234 00001234 0 00000000 00000044
sub 16 00008000 00000001 0 00007fff 00000814
sub 32 00000005 00000007 0 fffffffe 00000091
sub 32 80000000 00000001 0 7fffffff 00000814
or 8 00000080 00000001 0 00000081 00000084
and 32 f0f0f0f0 0f0f0f0f 0 00000000 00000044
std 32 00000000 00000000 0 00000000 00000444
add 32 12345678 11111111 0 23456789 00000400
shl 8 000000c1 00000000 1 00000082 00000485
shl 8 00000025 00000000 5 000000a0 00000c84
shl 8 000000ff 00000000 31 00000000 00000444
shl 16 00004000 00000000 1 00008000 00000c84
shl 16 00000c01 00000000 5 00008020 00000481
shl 8 deadbeef 00000000 0 000000ef 00000481
cld 32 00000000 00000000 0 00000000 00000081
shl 16 00001234 00000000 31 00000000 00000044
shl 32 80000001 00000000 1 00000002 00000801
shl 32 080000ff 00000000 5 00001fe0 00000801
shl 32 00000003 00000000 31 80000000 00000085

/* exec_unit.f */
verilog/exec_pkg.sv
verilog/exec_ctrl.sv
verilog/shift_counter.sv
verilog/alu_datapath.sv
verilog/flag_logic.sv
verilog/eflags_reg.sv
verilog/exec_unit.sv
bench/exec_unit_checker.sv
bench/exec_unit_tb.sv

/* verilog/alu_datapath.sv */
/*
 * Working data path of the execute unit.
 * On load it computes ADD, SUB or a logic op and registers the masked
 * result with sign and carry bits; for SHL it loads operand a instead and
 * shifts one bit per step at the registered size.
 */
module alu_datapath (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load,
	input  logic                step,
	input  exec_pkg::exec_req_t req,
	output logic [31:0]         result,
	output logic                carry_top,
	output logic                half_carry,
	output logic                a_top,
	output logic                b_top,
	output logic                shift_out,
	output exec_pkg::exec_op_e  op_q,
	output exec_pkg::op_size_e  size_q
);
	import exec_pkg::*;

	logic [31:0] mask;
	logic [31:0] a_m;
	logic [31:0] b_m;
	logic [32:0] sum;
	logic [32:0] diff;
	logic [31:0] load_res;
	logic        load_carry;
	logic        load_half;
	logic [31:0] shifted;

	//----------------------------------------------------------------------
	// Single-cycle function of the incoming request
	//----------------------------------------------------------------------
	always_comb begin
		mask       = size_mask(req.size);
		a_m        = req.a & mask;
		b_m        = req.b & mask;
		sum        = {1'b0, a_m} + {1'b0, b_m};
		// Negative difference sets every bit above the size
		diff       = {1'b0, a_m} - {1'b0, b_m};
		load_res   = 32'd0;
		load_carry = 1'b0;
		load_half  = 1'b0;
		case (req.op)
			op_add: begin
				load_res   = sum[31:0];
				// Bit one above the top, via the shifted view
				load_carry = top_bit(sum[32:1], req.size);
				load_half  = a_m[4] ^ b_m[4] ^ sum[4];
			end
			op_sub: begin
				load_res   = diff[31:0];
				load_carry = top_bit(diff[32:1], req.size);
				load_half  = a_m[4] ^ b_m[4] ^ diff[4];
			end
			op_and:  load_res = a_m & b_m;
			op_or:   load_res = a_m | b_m;
			op_xor:  load_res = a_m ^ b_m;
			// Shift source, stepped later
			op_shl:  load_res = a_m;
			// CLD and STD return zero
			default: load_res = 32'd0;
		endcase
	end

	// One-bit left shift at the registered size
	assign shifted = (result << 1) & size_mask(size_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result     <= 32'd0;
			carry_top  <= 1'b0;
			half_carry <= 1'b0;
			a_top      <= 1'b0;
			b_top      <= 1'b0;
			shift_out  <= 1'b0;
			op_q       <= op_add;
			size_q     <= size_8;
		end else if (load) begin
			result     <= load_res & mask;
			carry_top  <= load_carry;
			half_carry <= load_half;
			a_top      <= top_bit(req.a, req.size);
			b_top      <= top_bit(req.b, req.size);
			shift_out  <= 1'b0;
			op_q       <= req.op;
			size_q     <= req.size;
		end else if (step) begin
			// Last bit out becomes CF
			shift_out <= top_bit(result, size_q);
			result    <= shifted;
		end
	end

endmodule

/* verilog/eflags_reg.sv */
/*
 * Architectural EFLAGS register.
 * Places the flag group at its x86 bit positions on finish.
 */
module eflags_reg (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 finish,
	input  exec_pkg::flag_bits_t flags,
	output exec_pkg::eflags_t    eflags
);
	import exec_pkg::*;

	eflags_t flags_placed;

	// Reserved fields stay zero
	always_comb begin
		flags_placed    = '0;
		flags_placed.of = flags.of;
		flags_placed.df = flags.df;
		flags_placed.sf = flags.sf;
		flags_placed.zf = flags.zf;
		flags_placed.af = flags.af;
		flags_placed.pf = flags.pf;
		flags_placed.cf = flags.cf;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			eflags <= '0;
		end else if (finish) begin
			// Visible together with done
			eflags <= flags_placed;
		end
	end

endmodule

/* verilog/exec_ctrl.sv */
/*
 * Sequencer for the execute unit.
 * Accepts one request at a time, runs the single execute cycle or the
 * shift loop, and strobes the EFLAGS update one cycle ahead of done.
 */
module exec_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  exec_pkg::exec_op_e op,
	input  logic               count_zero,
	input  logic               shift_zero,
	output logic               load,
	output logic               step,
	output logic               finish,
	output logic               busy,
	output logic               done
);
	import exec_pkg::*;

	typedef enum logic [1:0] {idle, exec, shift, fin} state_e;

	state_e state;
	state_e state_nxt;
	// Captured at acceptance
	logic   shl_q;
	logic   zero_q;
	logic   accept;
	logic   do_shift;

	// Busy low in idle and fin, so a new start is taken in either
	assign accept   = start && (state == idle || state == fin);
	assign do_shift = shl_q && !zero_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= idle;
			shl_q  <= 1'b0;
			zero_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				shl_q  <= (op == op_shl);
				zero_q <= count_zero;
			end
		end
	end

	//----------------------------------------------------------------------
	// Next state
	//----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			idle:    if (accept) state_nxt = exec;
			exec:    state_nxt = do_shift ? shift : fin;
			// Wait out the counter
			shift:   if (shift_zero) state_nxt = fin;
			fin:     state_nxt = accept ? exec : idle;
			default: state_nxt = idle;
		endcase
	end

	// First shift step already in exec
	assign load   = accept;
	assign step   = (state == exec && do_shift) || (state == shift && !shift_zero);
	// SHL by zero never strobes finish, so all flags hold
	assign finish = (state == exec && !shl_q) || (state == shift && shift_zero);
	assign busy   = (state == exec) || (state == shift);
	assign done   = (state == fin);

endmodule

/* verilog/exec_pkg.sv */
/*
 * Shared types for the integer execute unit.
 * Holds the request and response records, the opcode and size encodings,
 * the EFLAGS bit layout and two small size helpers. Compile it first.
 */
package exec_pkg;

	// Opcodes accepted by the unit
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_shl = 3'd5,
		op_cld = 3'd6,
		op_std = 3'd7
	} exec_op_e;

	// Operand size, encoding 3 behaves as 32-bit
	typedef enum logic [1:0] {
		size_8  = 2'd0,
		size_16 = 2'd1,
		size_32 = 2'd2
	} op_size_e;

	// Request, sampled together with start
	typedef struct packed {
		exec_op_e    op;
		op_size_e    size;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  count;
	} exec_req_t;

	// Flag group before it is placed into EFLAGS
	typedef struct packed {
		logic of;
		logic df;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} flag_bits_t;

	//----------------------------------------------------------------------
	// EFLAGS layout, x86 bit positions, reserved fields read zero
	//----------------------------------------------------------------------
	typedef struct packed {
		logic [19:0] rsvd_31_12;
		logic        of;
		logic        df;
		logic [1:0]  rsvd_9_8;
		logic        sf;
		logic        zf;
		logic        rsvd_5;
		logic        af;
		logic        rsvd_3;
		logic        pf;
		logic        rsvd_1;
		logic        cf;
	} eflags_t;

	// Response, result is zero above the operand size
	typedef struct packed {
		logic [31:0] result;
		eflags_t     flags;
	} exec_rsp_t;

	// Low-order bits kept at a given size
	function automatic logic [31:0] size_mask(op_size_e size);
		case (size)
			size_8:  return 32'h0000_00ff;
			size_16: return 32'h0000_ffff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	// Sign position at a given size: bit 7, 15 or 31
	function automatic logic top_bit(logic [31:0] value, op_size_e size);
		case (size)
			size_8:  return value[7];
			size_16: return value[15];
			default: return value[31];
		endcase
	endfunction

endpackage

/* verilog/exec_unit.sv */
/*
 * Top level of the integer execute unit.
 * Start and req are sampled together while busy is low; rsp is held in
 * registers and valid from the done pulse onward.
 */
module exec_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  exec_pkg::exec_req_t  req,
	output logic                 busy,
	output logic                 done,
	output exec_pkg::exec_rsp_t  rsp
);
	import exec_pkg::*;

	// Control strobes
	logic        load;
	logic        step;
	logic        finish;
	logic        shift_zero;
	// Working data toward the flag logic
	logic [31:0] result;
	logic        carry_top;
	logic        half_carry;
	logic        a_top;
	logic        b_top;
	logic        shift_out;
	exec_op_e    op_q;
	op_size_e    size_q;
	flag_bits_t  flag_bits;
	eflags_t     eflags;

	exec_ctrl u_exec_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.op         (req.op),
		.count_zero (req.count == 5'd0),
		.shift_zero (shift_zero),
		.load       (load),
		.step       (step),
		.finish     (finish),
		.busy       (busy),
		.done       (done)
	);

	shift_counter u_shift_counter (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (load),
		.step  (step),
		.count (req.count),
		.zero  (shift_zero)
	);

	alu_datapath u_alu_datapath (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.step       (step),
		.req        (req),
		.result     (result),
		.carry_top  (carry_top),
		.half_carry (half_carry),
		.a_top      (a_top),
		.b_top      (b_top),
		.shift_out  (shift_out),
		.op_q       (op_q),
		.size_q     (size_q)
	);

	flag_logic u_flag_logic (
		.op         (op_q),
		.size       (size_q),
		.result     (result),
		.carry_top  (carry_top),
		.half_carry (half_carry),
		.a_top      (a_top),
		.b_top      (b_top),
		.shift_out  (shift_out),
		.flags_in   (eflags),
		.flags      (flag_bits)
	);

	eflags_reg u_eflags_reg (
		.clk    (clk),
		.rst_n  (rst_n),
		.finish (finish),
		.flags  (flag_bits),
		.eflags (eflags)
	);

	assign rsp = '{result: result, flags: eflags};

endmodule

/* verilog/flag_logic.sv */
/*
 * Size-aware EFLAGS generation, purely combinational.
 * Builds OF, SF, ZF, AF, PF and CF from the registered working result,
 * and passes the current flags through for ops that leave them alone.
 */
module flag_logic (
	input  exec_pkg::exec_op_e  op,
	input  exec_pkg::op_size_e  size,
	input  logic [31:0]         result,
	input  logic                carry_top,
	input  logic                half_carry,
	input  logic                a_top,
	input  logic                b_top,
	input  logic                shift_out,
	input  exec_pkg::eflags_t   flags_in,
	output exec_pkg::flag_bits_t flags
);
	import exec_pkg::*;

	logic       sign;
	logic [3:0] par_pair;
	logic [1:0] par_nib;
	logic       parity;
	logic       zero8;
	logic       zero16;
	logic       zero32;
	logic       zero_sel;

	//----------------------------------------------------------------------
	// Sign at the selected size
	//----------------------------------------------------------------------
	assign sign = top_bit(result, size);

	// Parity tree over the low byte, pairs first
	assign par_pair[3] = result[7] ^ result[6];
	assign par_pair[2] = result[5] ^ result[4];
	assign par_pair[1] = result[3] ^ result[2];
	assign par_pair[0] = result[1] ^ result[0];
	assign par_nib[1]  = par_pair[3] ^ par_pair[2];
	assign par_nib[0]  = par_pair[1] ^ par_pair[0];
	// Set on an even count of ones
	assign parity      = ~(par_nib[1] ^ par_nib[0]);

	// Zero detect grows with the size
	assign zero8  = ~|result[7:0];
	assign zero16 = zero8 & ~|result[15:8];
	assign zero32 = zero16 & ~|result[31:16];

	always_comb begin
		case (size)
			size_8:  zero_sel = zero8;
			size_16: zero_sel = zero16;
			default: zero_sel = zero32;
		endcase
	end

	//----------------------------------------------------------------------
	// Per-op selection
	//----------------------------------------------------------------------
	always_comb begin
		// Old values unless the op says otherwise
		flags.of = flags_in.of;
		flags.df = flags_in.df;
		flags.sf = flags_in.sf;
		flags.zf = flags_in.zf;
		flags.af = flags_in.af;
		flags.pf = flags_in.pf;
		flags.cf = flags_in.cf;
		case (op)
			op_add, op_sub: begin
				flags.cf = carry_top;
				flags.af = half_carry;
				// Add wraps on equal signs, sub on differing signs
				if (op == op_add)
					flags.of = (a_top == b_top) && (sign != a_top);
				else
					flags.of = (a_top != b_top) && (sign != a_top);
				flags.sf = sign;
				flags.zf = zero_sel;
				flags.pf = parity;
			end
			op_and, op_or, op_xor: begin
				flags.cf = 1'b0;
				flags.of = 1'b0;
				flags.af = 1'b0;
				flags.sf = sign;
				flags.zf = zero_sel;
				flags.pf = parity;
			end
			op_shl: begin
				flags.cf = shift_out;
				flags.of = sign ^ shift_out;
				flags.af = 1'b0;
				flags.sf = sign;
				flags.zf = zero_sel;
				flags.pf = parity;
			end
			op_cld:  flags.df = 1'b0;
			op_std:  flags.df = 1'b1;
			default: flags.df = flags_in.df;
		endcase
	end

endmodule

/* verilog/shift_counter.sv */
/*
 * Remaining-step counter for the shift loop.
 * Loaded with the requested count at acceptance, decremented per step.
 */
module shift_counter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load,
	input  logic       step,
	input  logic [4:0] count,
	output logic       zero
);
	// Steps still to go
	logic [4:0] remain;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			remain <= 5'd0;
		end else if (load) begin
			remain <= count;
		end else if (step && remain != 5'd0) begin
			// Never wraps below zero
			remain <= remain - 5'd1;
		end
	end

	// Combinational, seen by the controller in the same cycle
	assign zero = (remain == 5'd0);

endmodule
